/* logic/ps2_pkg.sv */
// PS/2 keyboard host interface, shared definitions
// holds the clock-derived timer lengths, the frame layout, the release
// prefix code and the line engine state type
`default_nettype none

package ps2_pkg;

  // ---------------------------------------------------------------------------
  // timing, derived from the assumed system clock
  // ---------------------------------------------------------------------------
  localparam int CLK_FREQ_HZ = 10_000_000;

  // 60 us of inhibit, also used as the receive watchdog
  localparam int INHIBIT_CYCLES = (CLK_FREQ_HZ / 1_000_000) * 60;
  // 5 us of settle after a clock edge while the host transmits
  localparam int SETTLE_CYCLES = (CLK_FREQ_HZ / 1_000_000) * 5;

  // counter widths, wide enough to hold the terminal count itself
  localparam int INHIBIT_BITS = $clog2(INHIBIT_CYCLES + 1);
  localparam int SETTLE_BITS = $clog2(SETTLE_CYCLES + 1);

  // ---------------------------------------------------------------------------
  // frame layout and codes
  // ---------------------------------------------------------------------------
  // start bit, eight data bits lsb first, odd parity, stop bit
  localparam int FRAME_BITS = 11;

  // the keyboard sends this before the code of a released key
  localparam logic [7:0] RELEASE_CODE = 8'hF0;

  typedef logic [7:0] scan_code_t;

  // line engine states, receive side first and then the host write sequence
  typedef enum logic [3:0] {
    rx_clk_h, rx_clk_l, rx_fall_mark, rx_rise_mark,
    tx_reset_timer, tx_force_clk_l, tx_first_wait_clk_h, tx_wait_clk_h,
    tx_rise_mark, tx_clk_h, tx_clk_l, tx_wait_ack,
    tx_done_recovery, tx_no_ack
  } line_state_t;

endpackage

`default_nettype wire

/* logic/ps2_timer_if.sv */
// PS/2 keyboard host interface, timer control bundle
// carries the run enables from the line engine to the two timers and the
// done flags back to the engine
`default_nettype none

interface ps2_timer_if;

  // 60 us inhibit / receive watchdog timer
  logic inhibit_en;
  logic inhibit_done;

  // 5 us settle timer, only used while the host transmits
  logic settle_en;
  logic settle_done;

  // line engine side, it runs the timers and watches for expiry
  modport engine (
    output inhibit_en,
    output settle_en,
    input  inhibit_done,
    input  settle_done
  );

  // timer side
  modport timer (
    input  inhibit_en,
    input  settle_en,
    output inhibit_done,
    output settle_done
  );

endinterface

`default_nettype wire

/* logic/ps2_timers.sv */
// PS/2 keyboard host interface, interval timers
// two saturating counters, the 60 us inhibit/watchdog timer and the 5 us
// settle timer, each held at zero while its enable is low
`default_nettype none

module ps2_timers
  import ps2_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  ps2_timer_if.timer tmr
);

  logic [INHIBIT_BITS-1:0] inhibit_cnt_q;
  logic [SETTLE_BITS-1:0]  settle_cnt_q;

  // done stays up for as long as the enable is held once the count is reached
  assign tmr.inhibit_done = (inhibit_cnt_q == INHIBIT_BITS'(INHIBIT_CYCLES));
  assign tmr.settle_done  = (settle_cnt_q == SETTLE_BITS'(SETTLE_CYCLES));

  // ---------------------------------------------------------------------------
  // inhibit / watchdog counter
  // ---------------------------------------------------------------------------
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      inhibit_cnt_q <= '0;
    else if (!tmr.inhibit_en)
      inhibit_cnt_q <= '0;
    // saturate at the terminal count so done does not wrap away
    else if (!tmr.inhibit_done)
      inhibit_cnt_q <= inhibit_cnt_q + 1'b1;
  end

  // ---------------------------------------------------------------------------
  // settle counter
  // ---------------------------------------------------------------------------
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      settle_cnt_q <= '0;
    else if (!tmr.settle_en)
      settle_cnt_q <= '0;
    else if (!tmr.settle_done)
      settle_cnt_q <= settle_cnt_q + 1'b1;
  end

  // a state that drops the enable for one cycle must restart the interval
  a_inhibit_restart: assert property (@(posedge clk) disable iff (reset)
    !tmr.inhibit_en |=> !tmr.inhibit_done)
    else $error("inhibit done without a fresh interval");

  a_settle_restart: assert property (@(posedge clk) disable iff (reset)
    !tmr.settle_en |=> !tmr.settle_done)
    else $error("settle done without a fresh interval");

endmodule

`default_nettype wire

/* logic/ps2_line_engine.sv */
// PS/2 keyboard host interface, line engine
// synchronizes the PS/2 clock and data lines, follows the keyboard clock
// to shift in received frames and shift out host command bytes, and
// drives both lines through open-collector enables
`default_nettype none

module ps2_line_engine
  import ps2_pkg::*;
(
  input  logic        clk,
  input  logic        reset,
  input  logic        ps2_clk_i,
  input  logic        ps2_data_i,
  input  logic        tx_write_i,
  input  scan_code_t  tx_data_i,
  output logic        ps2_clk_en_o,
  output logic        ps2_data_en_o,
  output logic        tx_write_ack_o,
  output logic        tx_error_o,
  output logic        frame_done_o,
  output scan_code_t  frame_code_o,
  ps2_timer_if.engine tmr
);

  logic clk_meta_q;
  logic data_meta_q;
  logic clk_s_q;
  logic data_s_q;

  line_state_t state_q;
  line_state_t state_d;

  logic [3:0]            bit_count_q;
  logic [FRAME_BITS-1:0] shift_q;
  logic                  shift_en;
  logic                  tx_last_bit;
  logic                  watchdog_clear;

  // ---------------------------------------------------------------------------
  // input synchronizers
  // ---------------------------------------------------------------------------
  // idle lines are pulled up, so the flops come out of reset high
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      clk_meta_q  <= 1'b1;
      data_meta_q <= 1'b1;
      clk_s_q     <= 1'b1;
      data_s_q    <= 1'b1;
    end
    else
    begin
      clk_meta_q  <= ps2_clk_i;
      data_meta_q <= ps2_data_i;
      clk_s_q     <= clk_meta_q;
      data_s_q    <= data_meta_q;
    end
  end

  // ---------------------------------------------------------------------------
  // line state machine
  // ---------------------------------------------------------------------------
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      state_q <= rx_clk_h;
    else
      state_q <= state_d;
  end

  always_comb
  begin
    // lines released and both timers idle unless a state says otherwise
    state_d        = state_q;
    ps2_clk_en_o   = 1'b1;
    ps2_data_en_o  = 1'b1;
    tmr.inhibit_en = 1'b0;
    tmr.settle_en  = 1'b0;
    case (state_q)
      // receive idle or mid-frame; the inhibit timer runs as the watchdog
      rx_clk_h:
      begin
        tmr.inhibit_en = 1'b1;
        if (tx_write_i)
          state_d = tx_reset_timer;
        else if (!clk_s_q)
          state_d = rx_fall_mark;
      end
      rx_clk_l:
      begin
        tmr.inhibit_en = 1'b1;
        if (tx_write_i)
          state_d = tx_reset_timer;
        else if (clk_s_q)
          state_d = rx_rise_mark;
      end
      // one-cycle markers, the fall marker samples the data line
      rx_fall_mark: state_d = rx_clk_l;
      rx_rise_mark: state_d = rx_clk_h;
      // one cycle with the inhibit timer off so it restarts from zero
      tx_reset_timer: state_d = tx_force_clk_l;
      // hold the clock low for the full inhibit time
      tx_force_clk_l:
      begin
        tmr.inhibit_en = 1'b1;
        ps2_clk_en_o   = 1'b0;
        if (tmr.inhibit_done)
          state_d = tx_first_wait_clk_h;
      end
      // request to send, start bit on the data line and clock released
      tx_first_wait_clk_h:
      begin
        tmr.settle_en = 1'b1;
        ps2_data_en_o = 1'b0;
        if (!clk_s_q && tmr.settle_done)
          state_d = tx_clk_l;
      end
      // wait out the settle time after the keyboard raises its clock
      tx_wait_clk_h:
      begin
        tmr.settle_en = 1'b1;
        ps2_data_en_o = shift_q[0];
        if (clk_s_q && tmr.settle_done)
          state_d = tx_rise_mark;
      end
      tx_rise_mark:
      begin
        ps2_data_en_o = shift_q[0];
        state_d       = tx_clk_h;
      end
      tx_clk_h:
      begin
        ps2_data_en_o = shift_q[0];
        if (tx_last_bit)
          state_d = tx_wait_ack;
        else if (!clk_s_q)
          state_d = tx_clk_l;
      end
      tx_clk_l:
      begin
        ps2_data_en_o = shift_q[0];
        if (clk_s_q)
          state_d = tx_wait_clk_h;
      end
      // data line released; the keyboard pulls data low on a falling clock
      tx_wait_ack:
      begin
        if (!clk_s_q && data_s_q)
          state_d = tx_no_ack;
        else if (!clk_s_q && !data_s_q)
          state_d = tx_done_recovery;
      end
      // both recovery states wait for the keyboard to let go of the lines
      tx_done_recovery, tx_no_ack:
      begin
        if (clk_s_q && data_s_q)
          state_d = rx_clk_h;
      end
      default: state_d = rx_clk_h;
    endcase
  end

  assign tx_error_o = (state_q == tx_no_ack);

  // the write is taken only between bits of a receive, never mid-transmit
  assign tx_write_ack_o = tx_write_i && ((state_q == rx_clk_h) || (state_q == rx_clk_l));

  // ---------------------------------------------------------------------------
  // bit counter and shift register
  // ---------------------------------------------------------------------------
  assign shift_en       = (state_q == rx_fall_mark) || (state_q == tx_rise_mark);
  assign tx_last_bit    = (bit_count_q == 4'(FRAME_BITS - 1));
  assign frame_done_o   = (bit_count_q == 4'(FRAME_BITS));
  assign frame_code_o   = shift_q[8:1];
  // a clock parked high past the watchdog time ends a partial frame
  assign watchdog_clear = tmr.inhibit_done && (state_q == rx_clk_h) && clk_s_q;

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      bit_count_q <= '0;
    else if (frame_done_o || (state_q == tx_wait_ack) || watchdog_clear)
      bit_count_q <= '0;
    else if (shift_en)
      bit_count_q <= bit_count_q + 4'd1;
  end

  // loaded lsb first as start, data, odd parity, stop
  always_ff @(posedge clk)
  begin
    if (tx_write_ack_o)
      shift_q <= {1'b1, ~^tx_data_i, tx_data_i, 1'b0};
    else if (shift_en)
      shift_q <= {data_s_q, shift_q[FRAME_BITS-1:1]};
  end

  // the keyboard stays inhibited for the full 60 us before the clock is let go
  a_clk_low_inhibit: assert property (@(posedge clk) disable iff (reset)
    $rose(ps2_clk_en_o) |-> $past(!ps2_clk_en_o, INHIBIT_CYCLES))
    else $error("clock line released before the inhibit time ran out");

  a_frame_done_pulse: assert property (@(posedge clk) disable iff (reset)
    frame_done_o |=> !frame_done_o)
    else $error("frame done held for more than one cycle");

endmodule

`default_nettype wire

/* logic/ps2_scan_result.sv */
// PS/2 keyboard host interface, scan code result stage
// folds the release prefix into a flag on the next code, registers the
// code for the host and keeps ready up until the host reads it
`default_nettype none

module ps2_scan_result
  import ps2_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  logic       frame_done_i,
  input  scan_code_t frame_code_i,
  input  logic       translate_i,
  input  logic       rx_read_i,
  output logic       rx_released_o,
  output scan_code_t rx_scan_code_o,
  output logic       rx_data_ready_o
);

  logic is_prefix;
  logic code_strobe;
  logic hold_released_q;

  // the prefix is only swallowed while translation is on
  assign is_prefix   = frame_done_i && translate_i && (frame_code_i == RELEASE_CODE);
  assign code_strobe = frame_done_i && !is_prefix;

  // ---------------------------------------------------------------------------
  // release flag and ready level
  // ---------------------------------------------------------------------------
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      hold_released_q <= 1'b0;
      rx_released_o   <= 1'b0;
      rx_data_ready_o <= 1'b0;
    end
    else
    begin
      if (code_strobe)
      begin
        // the held flag goes out with this code and the hold starts over
        rx_released_o   <= hold_released_q;
        hold_released_q <= 1'b0;
      end
      else if (is_prefix)
        hold_released_q <= 1'b1;

      // a new code wins over a read in the same cycle
      if (code_strobe)
        rx_data_ready_o <= 1'b1;
      else if (rx_read_i)
        rx_data_ready_o <= 1'b0;
    end
  end

  // ---------------------------------------------------------------------------
  // scan code register
  // ---------------------------------------------------------------------------
  // overwritten by each new code, whether or not the last one was read
  always_ff @(posedge clk)
  begin
    if (code_strobe)
      rx_scan_code_o <= frame_code_i;
  end

  a_ready_after_code: assert property (@(posedge clk) disable iff (reset)
    $rose(rx_data_ready_o) |-> $past(code_strobe))
    else $error("ready raised without a completed non-prefix frame");

endmodule

`default_nettype wire

/* logic/ps2_keyboard.sv */
// PS/2 keyboard host interface, top level
// receives scan codes from the keyboard and sends host command bytes,
// with open-collector enables for the clock and data lines
// the line engine runs the wire protocol, the timers give the 60 us and
// 5 us intervals and the result stage presents codes to the host
`default_nettype none

module ps2_keyboard
  import ps2_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  logic       ps2_clk_i,
  input  logic       ps2_data_i,
  input  logic       rx_read_i,
  input  logic       translate_i,
  input  logic       tx_write_i,
  input  scan_code_t tx_data_i,
  output logic       ps2_clk_en_o,
  output logic       ps2_data_en_o,
  output logic       rx_released_o,
  output scan_code_t rx_scan_code_o,
  output logic       rx_data_ready_o,
  output logic       tx_write_ack_o,
  output logic       tx_error_o
);

  logic       frame_done;
  scan_code_t frame_code;

  // timer enables and done flags between the engine and the timers
  ps2_timer_if u_timer_if ();

  ps2_line_engine u_line_engine (
    .clk            (clk),
    .reset          (reset),
    .ps2_clk_i      (ps2_clk_i),
    .ps2_data_i     (ps2_data_i),
    .tx_write_i     (tx_write_i),
    .tx_data_i      (tx_data_i),
    .ps2_clk_en_o   (ps2_clk_en_o),
    .ps2_data_en_o  (ps2_data_en_o),
    .tx_write_ack_o (tx_write_ack_o),
    .tx_error_o     (tx_error_o),
    .frame_done_o   (frame_done),
    .frame_code_o   (frame_code),
    .tmr            (u_timer_if)
  );

  ps2_timers u_timers (
    .clk   (clk),
    .reset (reset),
    .tmr   (u_timer_if)
  );

  ps2_scan_result u_scan_result (
    .clk             (clk),
    .reset           (reset),
    .frame_done_i    (frame_done),
    .frame_code_i    (frame_code),
    .translate_i     (translate_i),
    .rx_read_i       (rx_read_i),
    .rx_released_o   (rx_released_o),
    .rx_scan_code_o  (rx_scan_code_o),
    .rx_data_ready_o (rx_data_ready_o)
  );

endmodule

`default_nettype wire

/* sim/ps2_kbd_model.sv */
// PS/2 keyboard behavioral model
// sends device-to-host frames on its own clock and answers a host
// request to send by clocking the byte in and acknowledging it or not
// all line changes happen a short delay after a system clock edge
`default_nettype none

module ps2_kbd_model #(
  parameter int HALF_CYCLES = 200
) (
  input  logic clk,
  input  logic ps2_clk_i,
  input  logic ps2_data_i,
  output logic clk_drv_o,
  output logic data_drv_o
);
  timeunit 1ns;
  timeprecision 100ps;

  // both lines start released
  initial
  begin
    clk_drv_o  = 1'b1;
    data_drv_o = 1'b1;
  end

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk);
    #10;
  endtask

  // data changes in the middle of the high phase, the host samples on the fall
  task automatic send_bits(input logic [10:0] frame, input int nbits);
    for (int i = 0; i < nbits; i++)
    begin
      data_drv_o = frame[i];
      wait_cycles(HALF_CYCLES / 2);
      clk_drv_o = 1'b0;
      wait_cycles(HALF_CYCLES);
      clk_drv_o = 1'b1;
      wait_cycles(HALF_CYCLES / 2);
    end
    data_drv_o = 1'b1;
  endtask

  // a full frame with start bit, lsb first data, odd parity and stop bit
  task automatic send_frame(input logic [7:0] code);
    send_bits({1'b1, ~^code, code, 1'b0}, 11);
  endtask

  // waits for the host to inhibit the clock and release it with data low,
  // then clocks in eleven bits, sampling late in each high phase
  task automatic take_byte(input bit give_ack, output logic [10:0] bits);
    bits = '0;
    while (ps2_clk_i)
      wait_cycles(1);
    while (!ps2_clk_i)
      wait_cycles(1);
    for (int k = 0; k < 11; k++)
    begin
      wait_cycles((HALF_CYCLES * 3) / 4);
      bits[k] = ps2_data_i;
      // the acknowledge is data pulled low ahead of the eleventh fall
      if (k == 10 && give_ack)
        data_drv_o = 1'b0;
      wait_cycles(HALF_CYCLES / 4);
      clk_drv_o = 1'b0;
      wait_cycles(HALF_CYCLES);
      clk_drv_o  = 1'b1;
      data_drv_o = 1'b1;
    end
  endtask

endmodule

`default_nettype wire

/* sim/tb_ps2_keyboard.sv */
// PS/2 keyboard host interface testbench
// runs directed tests for reception, release prefix folding, host writes
// with and without acknowledge, and the receive watchdog
`default_nettype none

module tb_ps2_keyboard
  import ps2_pkg::*;
;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int HALF_CYCLES = 200;
  localparam int READY_LIMIT = 4 * FRAME_BITS * HALF_CYCLES;
  localparam int TX_LIMIT = 4 * FRAME_BITS * HALF_CYCLES + INHIBIT_CYCLES;
  // about twenty frames of PS/2 clock in ns, plus two ms of margin
  localparam longint FRAME_NS = longint'(FRAME_BITS) * 2 * HALF_CYCLES * 100;
  localparam longint WATCHDOG_NS = 20 * FRAME_NS + 2_000_000;

  logic clk;
  logic reset;
  logic rx_read;
  logic translate;
  logic tx_write;
  scan_code_t tx_data;
  logic ps2_clk_en;
  logic ps2_data_en;
  logic rx_released;
  scan_code_t rx_scan_code;
  logic rx_data_ready;
  logic tx_write_ack;
  logic tx_error;
  logic kbd_clk_drv;
  logic kbd_data_drv;
  logic ps2_clk;
  logic ps2_data;

  int errors;
  int tests_run;
  int tests_failed;

  // open-collector lines with pull-ups, low if either side pulls
  assign ps2_clk  = ps2_clk_en & kbd_clk_drv;
  assign ps2_data = ps2_data_en & kbd_data_drv;

  ps2_keyboard u_ps2_keyboard (
    .clk             (clk),
    .reset           (reset),
    .ps2_clk_i       (ps2_clk),
    .ps2_data_i      (ps2_data),
    .rx_read_i       (rx_read),
    .translate_i     (translate),
    .tx_write_i      (tx_write),
    .tx_data_i       (tx_data),
    .ps2_clk_en_o    (ps2_clk_en),
    .ps2_data_en_o   (ps2_data_en),
    .rx_released_o   (rx_released),
    .rx_scan_code_o  (rx_scan_code),
    .rx_data_ready_o (rx_data_ready),
    .tx_write_ack_o  (tx_write_ack),
    .tx_error_o      (tx_error)
  );

  ps2_kbd_model #(.HALF_CYCLES(HALF_CYCLES)) u_kbd (
    .clk        (clk),
    .ps2_clk_i  (ps2_clk),
    .ps2_data_i (ps2_data),
    .clk_drv_o  (kbd_clk_drv),
    .data_drv_o (kbd_data_drv)
  );

  always #50 clk = ~clk;

  // ------------------------------------------------------------------------
  // helpers
  // ------------------------------------------------------------------------
  task automatic step(input int n);
    repeat (n) @(posedge clk);
    #10;
  endtask

  task automatic compare_value(input string name, input int expected, input int actual);
    assert (expected == actual)
    else
    begin
      $display("mismatch %s: expected %0h actual %0h", name, expected, actual);
      errors++;
    end
  endtask

  task automatic report_failure(input string name, input string what);
    $display("%s: %s", name, what);
    errors++;
  endtask

  task automatic close_test(input string name, input int errors_before);
    tests_run++;
    if (errors != errors_before)
      tests_failed++;
    $display("test %s finished with %0d errors", name, errors - errors_before);
  endtask

  task automatic wait_ready(input string name);
    int n;
    n = 0;
    while (!rx_data_ready && n < READY_LIMIT)
    begin
      step(1);
      n++;
    end
    assert (rx_data_ready)
    else
      report_failure(name, "ready never rose after a frame");
  endtask

  // a one-cycle read, ready is expected low a cycle later
  task automatic read_code(input string name);
    rx_read = 1'b1;
    step(1);
    rx_read = 1'b0;
    step(1);
    compare_value({name, " ready after read"}, 0, int'(rx_data_ready));
  endtask

  task automatic host_write(input scan_code_t data);
    int n;
    n = 0;
    tx_data  = data;
    tx_write = 1'b1;
    #1;
    while (!tx_write_ack && n < TX_LIMIT)
    begin
      step(1);
      n++;
    end
    assert (tx_write_ack)
    else
      report_failure("host_write", "write never acknowledged by the DUT");
    // the byte loads on the edge where the acknowledge is seen
    step(1);
    tx_write = 1'b0;
  endtask

  function automatic scan_code_t random_code();
    scan_code_t c;
    c = RELEASE_CODE;
    while (c == RELEASE_CODE)
      c = scan_code_t'($urandom());
    return c;
  endfunction

  // ------------------------------------------------------------------------
  // directed tests
  // ------------------------------------------------------------------------
  task automatic test_reset_state();
    int e0;
    e0 = errors;
    compare_value("reset clk_en", 1, int'(ps2_clk_en));
    compare_value("reset data_en", 1, int'(ps2_data_en));
    compare_value("reset ready", 0, int'(rx_data_ready));
    compare_value("reset write_ack", 0, int'(tx_write_ack));
    compare_value("reset tx_error", 0, int'(tx_error));
    close_test("reset_state", e0);
  endtask

  task automatic test_receive_code();
    int e0;
    scan_code_t code;
    e0 = errors;
    code = random_code();
    u_kbd.send_frame(code);
    wait_ready("receive_code");
    compare_value("receive_code code", int'(code), int'(rx_scan_code));
    compare_value("receive_code released", 0, int'(rx_released));
    step(40);
    compare_value("receive_code ready held", 1, int'(rx_data_ready));
    read_code("receive_code");
    close_test("receive_code", e0);
  endtask

  task automatic test_release_prefix();
    int e0;
    scan_code_t code;
    e0 = errors;
    code = random_code();
    translate = 1'b1;
    u_kbd.send_frame(RELEASE_CODE);
    step(10);
    // the prefix alone must not raise ready
    compare_value("prefix ready", 0, int'(rx_data_ready));
    u_kbd.send_frame(code);
    wait_ready("release_prefix");
    compare_value("prefix code", int'(code), int'(rx_scan_code));
    compare_value("prefix released", 1, int'(rx_released));
    read_code("release_prefix");
    translate = 1'b0;
    u_kbd.send_frame(RELEASE_CODE);
    wait_ready("release_plain");
    compare_value("plain code", int'(RELEASE_CODE), int'(rx_scan_code));
    compare_value("plain released", 0, int'(rx_released));
    read_code("release_plain");
    close_test("release_prefix", e0);
  endtask

  task automatic test_host_write();
    int e0;
    scan_code_t data;
    scan_code_t code;
    logic [10:0] bits;
    bit byte_taken;
    bit error_seen;
    e0 = errors;
    byte_taken = 1'b0;
    error_seen = 1'b0;
    data = scan_code_t'($urandom());
    fork
      begin
        u_kbd.take_byte(1'b1, bits);
        byte_taken = 1'b1;
      end
      host_write(data);
      // tx_error must not rise at any point of an acknowledged write
      begin
        while (!byte_taken)
        begin
          if (tx_error)
            error_seen = 1'b1;
          step(1);
        end
      end
    join
    step(10);
    compare_value("write start bit", 0, int'(bits[0]));
    compare_value("write data", int'(data), int'(bits[8:1]));
    // data plus parity must hold an odd number of ones
    compare_value("write parity", 1, int'(^bits[9:1]));
    compare_value("write tx_error", 0, int'(error_seen));
    compare_value("write state", int'(rx_clk_h), int'(u_ps2_keyboard.u_line_engine.state_q));
    code = random_code();
    u_kbd.send_frame(code);
    wait_ready("write_then_receive");
    compare_value("write then receive code", int'(code), int'(rx_scan_code));
    read_code("write_then_receive");
    close_test("host_write", e0);
  endtask

  task automatic test_no_ack();
    int e0;
    int n;
    logic [10:0] bits;
    e0 = errors;
    n = 0;
    fork
      u_kbd.take_byte(1'b0, bits);
      begin
        host_write(scan_code_t'($urandom()));
        while (!tx_error && n < TX_LIMIT)
        begin
          step(1);
          n++;
        end
        assert (tx_error)
        else
          report_failure("no_ack", "tx_error never rose without an acknowledge");
      end
    join
    step(10);
    compare_value("no_ack error cleared", 0, int'(tx_error));
    close_test("no_ack", e0);
  endtask

  task automatic test_watchdog();
    int e0;
    scan_code_t code;
    e0 = errors;
    code = random_code();
    u_kbd.send_bits(11'h5A5, 4);
    // well past the 60 us watchdog
    step(2 * INHIBIT_CYCLES);
    u_kbd.send_frame(code);
    wait_ready("watchdog");
    compare_value("watchdog code", int'(code), int'(rx_scan_code));
    read_code("watchdog");
    close_test("watchdog", e0);
  endtask

  // ------------------------------------------------------------------------
  // main sequence and watchdog
  // ------------------------------------------------------------------------
  initial
  begin
    #(WATCHDOG_NS);
    $display("timeout, the tests did not finish in time");
    $display("Result: FAILED");
    $finish;
  end

  initial
  begin
    void'($urandom(58));
    clk          = 1'b0;
    reset        = 1'b1;
    rx_read      = 1'b0;
    translate    = 1'b0;
    tx_write     = 1'b0;
    tx_data      = '0;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    step(5);
    reset = 1'b0;
    step(2);
    test_reset_state();
    test_receive_code();
    test_release_prefix();
    test_host_write();
    test_no_ack();
    test_watchdog();
    $display("tests run %0d, tests failed %0d, checks failed %0d",
             tests_run, tests_failed, errors);
    if (errors == 0)
      $display("Result: PASSED");
    else
      $display("Result: FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* flist.f */
logic/ps2_pkg.sv
logic/ps2_timer_if.sv
logic/ps2_timers.sv
logic/ps2_line_engine.sv
logic/ps2_scan_result.sv
logic/ps2_keyboard.sv
sim/ps2_kbd_model.sv
sim/tb_ps2_keyboard.sv

/* run.sh */
#!/usr/bin/env bash
# builds the PS/2 keyboard testbench with Verilator and runs it
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert \
  -f flist.f \
  --top-module tb_ps2_keyboard \
  -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/Vtb_ps2_keyboard > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Result: FAILED" "$LOG"; then
  exit 1
fi
exit 0
